// ==== verilog/fetch_queue_cfg.svh ====
`ifndef FETCH_QUEUE_CFG_SVH
`define FETCH_QUEUE_CFG_SVH

// Queue storage depth as log2, 32 entries in the RAM FIFO
`define FETCHQ_DEPTH_LOG2 5

// Program counter width of the RV64 core
`define XLEN 64

`endif

// ==== verilog/taurus_fetch_pkg.sv ====
`include "fetch_queue_cfg.svh"

package taurus_fetch_pkg;

    // Word handed over by the fetch unit
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
    } fetch_packet_t;

    // Major opcode groups of RV64I, anything else is ILLEGAL
    typedef enum logic [3:0] {
        LOAD      = 4'd0,
        STORE     = 4'd1,
        BRANCH    = 4'd2,
        JAL       = 4'd3,
        JALR      = 4'd4,
        OP        = 4'd5,
        OP_IMM    = 4'd6,
        OP_32     = 4'd7,
        OP_IMM_32 = 4'd8,
        LUI       = 4'd9,
        AUIPC     = 4'd10,
        SYSTEM    = 4'd11,
        MISC_MEM  = 4'd12,
        ILLEGAL   = 4'd13
    } op_class_e;

    // One queue slot, predecoded fetch packet
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
        op_class_e        op_class;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        // Register usage hints for decode
        logic             uses_rd;
        logic             uses_rs1;
        logic             uses_rs2;
    } fq_entry_t;

endpackage

// ==== verilog/common_dffram_2a1w1r.sv ====
`timescale 1ns/1ns

module common_dffram_2a1w1r #(
    parameter RAM_DATA_WIDTH = 32,
    parameter RAM_ADDR_WIDTH = 5
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic [RAM_ADDR_WIDTH-1:0] addra,
    input  logic                      ena,
    input  logic                      wea,
    input  logic [RAM_DATA_WIDTH-1:0] dina,

    input  logic [RAM_ADDR_WIDTH-1:0] addrb,
    input  logic                      enb,
    output logic [RAM_DATA_WIDTH-1:0] doutb
);

    localparam RAM_WORDS = 1 << RAM_ADDR_WIDTH;

    logic [RAM_DATA_WIDTH-1:0] mem [RAM_WORDS];

    // Write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (ena && wea) begin
            mem[addra] <= dina;
        end
    end

    // Registered read port, holds its word while enb is low
    always_ff @(posedge clk) begin
        if (reset) begin
            doutb <= '0;
        end else if (enb) begin
            doutb <= mem[addrb];
        end
    end

    a_addra_known: assert property (@(posedge clk) disable iff (reset)
        (ena && wea) |-> !$isunknown(addra));
    a_addrb_known: assert property (@(posedge clk) disable iff (reset)
        enb |-> !$isunknown(addrb));

endmodule

// ==== verilog/common_fifo_ram_1w1r.sv ====
`timescale 1ns/1ns

module common_fifo_ram_1w1r #(
    parameter FIFO_DEPTH_LOG2 = 5,
    parameter FIFO_WIDTH      = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,

    input  logic [FIFO_WIDTH-1:0] din,
    input  logic                  wen,

    output logic [FIFO_WIDTH-1:0] dout,
    input  logic                  ren,

    output logic                  fifo_empty,
    output logic                  fifo_full
);

    // Pointers carry one extra wrap bit above the RAM address
    logic [FIFO_DEPTH_LOG2:0]   wptr_q;
    logic [FIFO_DEPTH_LOG2:0]   rptr_q;

    logic                       ptr_overlap;
    logic                       push;
    logic                       pop;

    assign ptr_overlap = wptr_q[FIFO_DEPTH_LOG2-1:0] == rptr_q[FIFO_DEPTH_LOG2-1:0];

    assign fifo_empty = ptr_overlap && (wptr_q[FIFO_DEPTH_LOG2] == rptr_q[FIFO_DEPTH_LOG2]);
    assign fifo_full  = ptr_overlap && (wptr_q[FIFO_DEPTH_LOG2] != rptr_q[FIFO_DEPTH_LOG2]);

    // Accepted operations; a write in a clear cycle is lost
    assign push = wen && !fifo_full && !clear;
    assign pop  = ren && !fifo_empty;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
        end
    end

    // Storage, read data shows up one cycle after the pop
    common_dffram_2a1w1r #(
        .RAM_DATA_WIDTH (FIFO_WIDTH),
        .RAM_ADDR_WIDTH (FIFO_DEPTH_LOG2)
    ) u_fifo_ram (
        .clk    (clk),
        .reset  (reset),

        .addra  (wptr_q[FIFO_DEPTH_LOG2-1:0]),
        .ena    (push),
        .wea    (push),
        .dina   (din),

        .addrb  (rptr_q[FIFO_DEPTH_LOG2-1:0]),
        .enb    (pop),
        .doutb  (dout)
    );

    a_not_empty_and_full: assert property (@(posedge clk) disable iff (reset)
        !(fifo_empty && fifo_full));

    // A lone push always leaves something to read
    a_push_fills: assert property (@(posedge clk) disable iff (reset)
        (push && !pop) |=> !fifo_empty);

    a_pop_frees: assert property (@(posedge clk) disable iff (reset)
        (pop && !push && !clear) |=> !fifo_full);

endmodule

// ==== verilog/inst_predecode.sv ====
`timescale 1ns/1ns

module inst_predecode (
    input  taurus_fetch_pkg::fetch_packet_t pkt,
    output taurus_fetch_pkg::fq_entry_t     entry
);

    import taurus_fetch_pkg::*;

    logic [6:0] opcode;
    logic [4:0] rd;
    op_class_e  op_class;

    assign opcode = pkt.inst[6:0];
    assign rd     = pkt.inst[11:7];

    // All listed opcodes end in 2'b11, so 16-bit encodings fall to default
    always_comb begin
        case (opcode)
            7'b0000011: op_class = LOAD;
            7'b0100011: op_class = STORE;
            7'b1100011: op_class = BRANCH;
            7'b1101111: op_class = JAL;
            7'b1100111: op_class = JALR;
            7'b0110011: op_class = OP;
            7'b0010011: op_class = OP_IMM;
            7'b0111011: op_class = OP_32;
            7'b0011011: op_class = OP_IMM_32;
            7'b0110111: op_class = LUI;
            7'b0010111: op_class = AUIPC;
            7'b1110011: op_class = SYSTEM;
            7'b0001111: op_class = MISC_MEM;
            default:    op_class = ILLEGAL;
        endcase
    end

    always_comb begin
        entry.pc       = pkt.pc;
        entry.inst     = pkt.inst;
        entry.op_class = op_class;
        entry.rd       = rd;
        entry.rs1      = pkt.inst[19:15];
        entry.rs2      = pkt.inst[24:20];

        // Destination register
        case (op_class)
            STORE, BRANCH, MISC_MEM, ILLEGAL: entry.uses_rd = 1'b0;
            // CSR ops with x0 destination write nothing
            SYSTEM:  entry.uses_rd = (rd != 5'd0);
            default: entry.uses_rd = 1'b1;
        endcase

        // First source
        case (op_class)
            LUI, AUIPC, JAL, ILLEGAL: entry.uses_rs1 = 1'b0;
            default:                  entry.uses_rs1 = 1'b1;
        endcase

        // Second source, R-type and S/B-type only
        case (op_class)
            STORE, BRANCH, OP, OP_32: entry.uses_rs2 = 1'b1;
            default:                  entry.uses_rs2 = 1'b0;
        endcase
    end

endmodule

// ==== verilog/fetch_queue_out.sv ====
`timescale 1ns/1ns

module fetch_queue_out (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,

    output logic                        ren,
    input  taurus_fetch_pkg::fq_entry_t dout,
    input  logic                        fifo_empty,

    output logic                        out_valid,
    output taurus_fetch_pkg::fq_entry_t out_entry,
    input  logic                        out_ready
);

    import taurus_fetch_pkg::*;

    // Slot 0 is always the head of the stream
    fq_entry_t  slot_q [2];
    logic [1:0] slot_valid_q;
    logic       inflight_q;
    logic       drop_q;

    fq_entry_t  slot_d [2];
    logic [1:0] slot_valid_d;
    logic       out_xfer;
    logic       rd_ret;
    logic [1:0] held;
    logic [1:0] credit_used;

    assign out_xfer = slot_valid_q[0] && out_ready;
    assign rd_ret   = inflight_q && !drop_q;

    // Slots still occupied after this cycle's transfer, plus the pending read
    assign held        = {1'b0, slot_valid_q[0]} + {1'b0, slot_valid_q[1]};
    assign credit_used = held + {1'b0, inflight_q} - {1'b0, out_xfer};

    assign ren = !fifo_empty && (credit_used < 2'd2);

    assign out_valid = slot_valid_q[0];
    assign out_entry = slot_q[0];

    always_comb begin
        slot_d       = slot_q;
        slot_valid_d = slot_valid_q;

        // Advance slot 1 to the head on a transfer
        if (out_xfer) begin
            slot_d[0]       = slot_q[1];
            slot_valid_d[0] = slot_valid_q[1];
            slot_valid_d[1] = 1'b0;
        end

        // Returning word lands in the first free slot
        if (rd_ret) begin
            if (!slot_valid_d[0]) begin
                slot_d[0]       = dout;
                slot_valid_d[0] = 1'b1;
            end else begin
                slot_d[1]       = dout;
                slot_valid_d[1] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            slot_valid_q <= '0;
        end else begin
            slot_valid_q <= slot_valid_d;
        end
    end

    // A read issued in the flush cycle comes back stale
    always_ff @(posedge clk) begin
        if (reset) begin
            inflight_q <= 1'b0;
            drop_q     <= 1'b0;
        end else begin
            inflight_q <= ren;
            drop_q     <= flush && ren;
        end
    end

    always_ff @(posedge clk) begin
        slot_q <= slot_d;
    end

    // Read credit must keep a slot free for every returning word
    a_slot_free_on_return: assert property (@(posedge clk) disable iff (reset)
        rd_ret |-> !(slot_valid_q[0] && slot_valid_q[1]));

    a_head_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_entry)));

endmodule

// ==== verilog/fetch_queue.sv ====
`timescale 1ns/1ns

`include "fetch_queue_cfg.svh"

module fetch_queue (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flush,

    input  logic                            in_valid,
    input  taurus_fetch_pkg::fetch_packet_t in_pkt,
    output logic                            in_ready,

    output logic                            out_valid,
    output taurus_fetch_pkg::fq_entry_t     out_entry,
    input  logic                            out_ready
);

    import taurus_fetch_pkg::*;

    fq_entry_t  pre_entry;
    fq_entry_t  fifo_dout;
    logic       fifo_wen;
    logic       fifo_ren;
    logic       fifo_empty;
    logic       fifo_full;

    assign in_ready = !fifo_full;
    assign fifo_wen = in_valid && in_ready;

    // Classify on the way in so decode gets the hints with the word
    inst_predecode u_predecode (
        .pkt    (in_pkt),
        .entry  (pre_entry)
    );

    common_fifo_ram_1w1r #(
        .FIFO_DEPTH_LOG2    (`FETCHQ_DEPTH_LOG2),
        .FIFO_WIDTH         ($bits(fq_entry_t))
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .clear      (flush),

        .din        (pre_entry),
        .wen        (fifo_wen),

        .dout       (fifo_dout),
        .ren        (fifo_ren),

        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full)
    );

    // Two-entry skid buffer toward decode
    fetch_queue_out u_out (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),

        .ren        (fifo_ren),
        .dout       (fifo_dout),
        .fifo_empty (fifo_empty),

        .out_valid  (out_valid),
        .out_entry  (out_entry),
        .out_ready  (out_ready)
    );

endmodule

// ==== testbench/fetch_queue_tb.sv ====
`timescale 1ns/1ns

`include "fetch_queue_cfg.svh"

module fetch_queue_tb;

    import taurus_fetch_pkg::*;

    localparam int NROWS = 18;
    localparam logic [`XLEN-1:0] PC_BASE = 64'h0000_0000_8000_0000;
    // The whole run needs about 1400 cycles
    localparam int MAX_CYCLES = 20000;

    // Stimulus row with uses as {rd, rs1, rs2}
    typedef struct packed {
        logic [31:0] inst;
        op_class_e   cls;
        logic [2:0]  uses;
    } row_t;

    row_t stim_table [NROWS] = '{
        '{32'h0085_2283, LOAD,      3'b110},   // lw    x5, 8(x10)
        '{32'h0061_2623, STORE,     3'b011},   // sw    x6, 12(x2)
        '{32'h0020_8463, BRANCH,    3'b011},   // beq   x1, x2, 8
        '{32'h0100_00ef, JAL,       3'b100},   // jal   x1, 16
        '{32'h0000_8067, JALR,      3'b110},   // jalr  x0, 0(x1)
        '{32'h0052_01b3, OP,        3'b111},   // add   x3, x4, x5
        '{32'h0010_0093, OP_IMM,    3'b110},   // addi  x1, x0, 1
        '{32'h0094_03bb, OP_32,     3'b111},   // addw  x7, x8, x9
        '{32'hfff1_011b, OP_IMM_32, 3'b110},   // addiw x2, x2, -1
        '{32'h1234_5537, LUI,       3'b100},   // lui   x10, 0x12345
        '{32'h0000_0597, AUIPC,     3'b100},   // auipc x11, 0
        '{32'h0000_0073, SYSTEM,    3'b010},   // ecall with rd x0
        '{32'h3003_12f3, SYSTEM,    3'b110},   // csrrw x5, mstatus, x6
        '{32'h0ff0_000f, MISC_MEM,  3'b010},   // fence
        '{32'h0000_007f, ILLEGAL,   3'b000},   // opcode 1111111
        '{32'h0000_202f, ILLEGAL,   3'b000},   // AMO opcode not in the list
        '{32'h0000_0505, ILLEGAL,   3'b000},   // low bits 01
        '{32'h0000_4082, ILLEGAL,   3'b000}    // low bits 10
    };

    logic          clk;
    logic          reset;
    logic          flush;
    logic          in_valid;
    fetch_packet_t in_pkt;
    logic          in_ready;
    logic          out_valid;
    fq_entry_t     out_entry;
    logic          out_ready;

    fq_entry_t     model_q [$];
    int            accepted_cnt = 0;
    int            cur_row = 0;
    int            cycle_cnt = 0;
    integer        seed = 32'h2edc_06db;
    logic          flush_seen = 1'b0;

    fetch_queue DUT (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_pkt    (in_pkt),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_entry (out_entry),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic value_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        stop_on_error();
    endtask

    // Expected entry from the packet and the row's class and flags
    function automatic fq_entry_t expected_entry(input fetch_packet_t pkt, input row_t row);
        fq_entry_t e;
        e.pc       = pkt.pc;
        e.inst     = pkt.inst;
        e.op_class = row.cls;
        e.rd       = pkt.inst[11:7];
        e.rs1      = pkt.inst[19:15];
        e.rs2      = pkt.inst[24:20];
        e.uses_rd  = row.uses[2];
        e.uses_rs1 = row.uses[1];
        e.uses_rs2 = row.uses[0];
        return e;
    endfunction

    task automatic check_output();
        fq_entry_t exp_e;
        if (model_q.size() == 0) begin
            $display("Output transfer at %0t ns with no entry outstanding", $time);
            stop_on_error();
        end else begin
            exp_e = model_q.pop_front();
            assert (out_entry == exp_e) else value_error($sformatf(
                "got pc %h inst %h class %0d uses %b, expected pc %h inst %h class %0d uses %b",
                out_entry.pc, out_entry.inst, out_entry.op_class,
                {out_entry.uses_rd, out_entry.uses_rs1, out_entry.uses_rs2},
                exp_e.pc, exp_e.inst, exp_e.op_class,
                {exp_e.uses_rd, exp_e.uses_rs1, exp_e.uses_rs2}));
        end
    endtask

    // Handshakes sampled mid-cycle complete at the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (flush_seen) begin
                assert (!out_valid) else value_error("out_valid high in the cycle after flush");
            end
            flush_seen = flush;
            if (flush) begin
                model_q.delete();
            end else begin
                if (out_valid && out_ready) begin
                    check_output();
                end
                if (in_valid && in_ready) begin
                    model_q.push_back(expected_entry(in_pkt, stim_table[cur_row]));
                    accepted_cnt++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            stop_on_error();
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Packet number i walks the table and moves pc on by one word
    task automatic drive_index(input int i);
        cur_row     = i % NROWS;
        in_pkt.pc   = PC_BASE + (64'(i) << 2);
        in_pkt.inst = stim_table[cur_row].inst;
    endtask

    task automatic run_traffic(input int count, input bit rand_mode, input bit out_level);
        int target;
        int rnd;
        target = accepted_cnt + count;
        while (accepted_cnt < target) begin
            rnd = $random(seed);
            drive_index(accepted_cnt);
            in_valid  = rand_mode ? rnd[0] : 1'b1;
            out_ready = rand_mode ? rnd[1] : out_level;
            step();
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while (model_q.size() != 0) begin
            step();
        end
    endtask

    // Flush after n entries while the next packet is offered
    task automatic flush_after(input int n);
        run_traffic(n, 1'b0, 1'b0);
        drive_index(accepted_cnt);
        in_valid  = 1'b1;
        out_ready = 1'b0;
        flush     = 1'b1;
        step();
        flush     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (4) step();
        run_traffic(6, 1'b0, 1'b1);
        wait_drained();
    endtask

    initial begin
        int start;
        int guard;

        reset     = 1'b1;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_pkt    = '0;
        out_ready = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        @(negedge clk);
        assert (!out_valid) else value_error("out_valid high after reset");
        assert (in_ready) else value_error("in_ready low after reset");
        step();

        // Every row in order including the ILLEGAL encodings
        run_traffic(NROWS, 1'b0, 1'b1);
        wait_drained();

        // Fill the FIFO and both output slots with decode stalled
        out_ready = 1'b0;
        in_valid  = 1'b1;
        start     = accepted_cnt;
        guard     = 0;
        while (in_ready && guard < 60) begin
            drive_index(accepted_cnt);
            step();
            guard++;
        end
        assert (accepted_cnt - start == 34) else value_error($sformatf(
            "%0d entries accepted before in_ready fell, expected 34", accepted_cnt - start));
        repeat (4) step();
        assert (!in_ready && accepted_cnt - start == 34)
            else value_error("queue accepted entries while full");
        wait_drained();

        // Random stalls on both sides
        run_traffic(500, 1'b1, 1'b0);
        wait_drained();

        // Flush with both slots full and then with a read in flight
        flush_after(10);
        flush_after(1);

        $display("No errors");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/taurus_fetch_pkg.sv
verilog/common_dffram_2a1w1r.sv
verilog/common_fifo_ram_1w1r.sv
verilog/inst_predecode.sv
verilog/fetch_queue_out.sv
verilog/fetch_queue.sv
testbench/fetch_queue_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch queue testbench with Verilator.
# A $fatal in the testbench gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module fetch_queue_tb \
    -f compile.f \
    -o fetch_queue_sim

./obj_dir/fetch_queue_sim
